// File: icache_sys.f
+incdir+src
src/icache_pkg.sv
src/mem_bus_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_ctrl.sv
src/icache_top.sv
test/icache_asserts.sv
test/tb_icache_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_icache_top \
    -f icache_sys.f -o sim_icache > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_icache > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

// File: src/icache_ctrl.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_ctrl
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // cpu side
    input  addr_t    cpu_req_addr,
    input  logic     cpu_req_valid,
    output word_t    cpu_req_data,
    output logic     cpu_req_ready,

    // memory side
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,

    // array read port
    output logic     rd_en,
    output index_t   rd_index,
    input  logic     rd_valid,
    input  tag_t     rd_tag,
    input  word_t    rd_data,

    // array refill port
    output logic     wr_en,
    output index_t   wr_index,
    output tag_t     wr_tag,
    output word_t    wr_data
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    addr_t  req_addr;
    index_t req_index;
    tag_t   req_tag;
    word_t  fill_data;

    logic accept;
    logic hit;
    logic miss;
    logic fill_done;

    // rd_en doubles as the lookup-in-flight flag while still in IDLE
    assign accept = (state == IDLE) && cpu_req_valid && !rd_en;

    assign req_index = req_addr[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_BITS];
    assign req_tag   = req_addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_BITS];

    // tag compare on the registered array outputs
    assign hit       = (state == COMPARE) && rd_valid && (rd_tag == req_tag);
    assign miss      = (state == COMPARE) && !hit;
    assign fill_done = (state == REFILL) && mem_rsp.ready;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (rd_en)
                    next_state = COMPARE;
            end
            COMPARE:
            begin
                if (hit)
                    next_state = IDLE;
                else
                    next_state = REFILL;
            end
            REFILL:
            begin
                if (mem_rsp.ready)
                    next_state = RESPOND;
            end
            RESPOND:
                next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    // issue the lookup one edge after the request is seen
    always_ff @(posedge clk)
    begin
        if (rst)
            rd_en <= 1'b0;
        else
            rd_en <= accept;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            req_addr <= cpu_req_addr;
    end

    // refill request, held until memory answers
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req.valid <= 1'b0;
        end
        else if (miss)
        begin
            mem_req.valid <= 1'b1;
            mem_req.addr  <= {req_addr[31:2], 2'b00};
        end
        else if (fill_done)
        begin
            mem_req.valid <= 1'b0;
        end
    end

    // word returned to the cpu in RESPOND
    always_ff @(posedge clk)
    begin
        if (fill_done)
            fill_data <= mem_rsp.data;
    end

    assign rd_index = req_index;

    // both arrays written in the ready cycle
    assign wr_en    = fill_done;
    assign wr_index = req_index;
    assign wr_tag   = req_tag;
    assign wr_data  = mem_rsp.data;

    assign cpu_req_ready = hit || (state == RESPOND);
    assign cpu_req_data  = (state == RESPOND) ? fill_data : rd_data;

endmodule

// File: src/icache_data_array.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_data_array
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rd_en,
    input  index_t rd_index,
    input  logic   wr_en,
    input  index_t wr_index,
    input  word_t  wr_data,
    output word_t  rd_data
);

    // one word per line, block RAM style
    word_t mem [`ICACHE_LINES];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_index] <= wr_data;
    end

    // synchronous read port
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_index];
    end

endmodule

// File: src/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

    // byte address of one instruction word
    typedef logic [31:0] addr_t;

    // fetched instruction
    typedef logic [31:0] word_t;

    // line select
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

    // stored tag per line
    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

// File: src/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// direct-mapped geometry, one 32-bit word per line
`define ICACHE_LINES 16
`define ICACHE_INDEX_BITS 4
`define ICACHE_TAG_BITS 12

// address field positions
// index is addr[5:2], tag is addr[17:6]
`define ICACHE_INDEX_LSB 2
`define ICACHE_TAG_LSB 6

// bits above the tag are not cached but still reach memory

`endif

// File: src/icache_tag_array.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tag_array
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   rd_en,
    input  index_t rd_index,
    input  logic   wr_en,
    input  index_t wr_index,
    input  tag_t   wr_tag,
    output logic   rd_valid,
    output tag_t   rd_tag
);

    logic [`ICACHE_LINES-1:0] valid_bits;
    tag_t                     tags [`ICACHE_LINES];

    // valid bits, flush beats a refill write
    always_ff @(posedge clk)
    begin
        if (rst || flush)
            valid_bits <= '0;
        else if (wr_en)
            valid_bits[wr_index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            tags[wr_index] <= wr_tag;
    end

    // registered lookup result
    always_ff @(posedge clk)
    begin
        if (rst)
            rd_valid <= 1'b0;
        else if (rd_en)
            rd_valid <= valid_bits[rd_index];
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_tag <= tags[rd_index];
    end

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ns

module icache_top
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  addr_t    cpu_req_addr,
    input  logic     cpu_req_valid,
    output word_t    cpu_req_data,
    output logic     cpu_req_ready,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    logic   rd_en;
    index_t rd_index;
    logic   rd_valid;
    tag_t   rd_tag;
    word_t  rd_data;
    logic   wr_en;
    index_t wr_index;
    tag_t   wr_tag;
    word_t  wr_data;

    icache_ctrl u_icache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .rd_valid      (rd_valid),
        .rd_tag        (rd_tag),
        .rd_data       (rd_data),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_tag        (wr_tag),
        .wr_data       (wr_data)
    );

    // flush bypasses the controller
    icache_tag_array u_icache_tag_array (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .rd_valid (rd_valid),
        .rd_tag   (rd_tag)
    );

    icache_data_array u_icache_data_array (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .rd_data  (rd_data)
    );

endmodule

// File: src/mem_bus_pkg.sv
package mem_bus_pkg;

    import icache_pkg::*;

    // refill request, addr is word aligned
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

    // refill response, ready is a one-cycle pulse
    typedef struct packed {
        logic  ready;
        word_t data;
    } mem_rsp_t;

endpackage

// File: test/icache_asserts.sv
`timescale 1ns/1ns

module icache_asserts
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input ctrl_state_t state,
    input logic        miss,
    input logic        cpu_req_ready,
    input mem_req_t    mem_req,
    input mem_rsp_t    mem_rsp
);

    // refill request held steady through back-pressure
    req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req.addr))
        else $error("mem_req dropped or changed before mem_rsp.ready");

    // cpu ready is a single-cycle pulse
    ready_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_req_ready |=> !cpu_req_ready)
        else $error("cpu_req_ready high for two cycles in state %0d", state);

    // a refill only starts from a tag miss
    refill_on_miss: assert property (@(posedge clk) disable iff (rst)
        !mem_req.valid && !miss |=> !mem_req.valid)
        else $error("mem_req.valid rose without a miss");

    reset_quiet: assert property (@(posedge clk)
        rst |=> !cpu_req_ready && !mem_req.valid)
        else $error("outputs not low after reset");

endmodule

bind icache_ctrl icache_asserts u_icache_asserts (
    .clk           (clk),
    .rst           (rst),
    .state         (state),
    .miss          (miss),
    .cpu_req_ready (cpu_req_ready),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp)
);

// File: test/tb_icache_top.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module tb_icache_top
    import icache_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int SKEW       = 2;
    localparam int WAIT_LIMIT = 64;

    logic     clk = 1'b0;
    logic     rst;
    logic     flush;
    addr_t    cpu_req_addr;
    logic     cpu_req_valid;
    word_t    cpu_req_data;
    logic     cpu_req_ready;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    logic [15:0] lfsr_state = 16'd28359;
    int          cycle = 0;
    int          refill_count = 0;
    int          issued = 0;
    int          responses = 0;
    int          issue_cycle = 0;
    int          refills_at_issue = 0;
    int          mem_delay = 0;
    logic        exp_miss = 1'b0;
    word_t       exp_data = '0;
    addr_t       exp_addr = '0;

    // shadow copy of valid bits and tags
    logic [`ICACHE_LINES-1:0] shadow_valid = '0;
    tag_t                     shadow_tag [`ICACHE_LINES];

    icache_top u_icache_top (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // backing memory holds a fixed scramble of the address
    function automatic word_t ref_mem_word(input addr_t addr);
        word_t w;
        w = (addr ^ 32'h5a3c_96e1) * 32'h9e37_79b1;
        return w ^ {w[15:0], w[31:16]};
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    // shadow model decides hit or miss before the fetch
    task automatic fetch_delayed(input addr_t addr, input int delay);
        index_t idx;
        tag_t   tag;
        int     waited;
        idx = addr[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_BITS];
        tag = addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_BITS];
        exp_miss = !(shadow_valid[idx] && shadow_tag[idx] == tag);
        exp_addr = {addr[31:2], 2'b00};
        exp_data = ref_mem_word(exp_addr);
        mem_delay = delay;
        refills_at_issue = refill_count;
        issue_cycle = cycle;
        issued++;
        cpu_req_addr = addr;
        cpu_req_valid = 1'b1;
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx] = tag;
        waited = 0;
        while (responses != issued)
        begin
            @(posedge clk);
            #SKEW;
            waited++;
            if (waited > WAIT_LIMIT)
                stop_with_error("timed out waiting for cpu_req_ready");
        end
        cpu_req_valid = 1'b0;
    endtask

    task automatic fetch(input addr_t addr);
        logic [31:0] r;
        take_bits(3, r);
        fetch_delayed(addr, int'(r[2:0]));
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(posedge clk);
        #SKEW;
        flush = 1'b0;
        shadow_valid = '0;
    endtask

    // memory model answers after mem_delay extra cycles
    initial
    begin : mem_model
        int    wait_cnt;
        logic  busy;
        addr_t held_addr;
        mem_rsp = '0;
        busy = 1'b0;
        wait_cnt = 0;
        held_addr = '0;
        forever
        begin
            @(posedge clk);
            #SKEW;
            mem_rsp.ready = 1'b0;
            if (busy && !mem_req.valid)
                stop_with_error("mem_req.valid dropped before the ready pulse");
            if (!rst && mem_req.valid)
            begin
                if (!busy)
                begin
                    busy = 1'b1;
                    wait_cnt = 0;
                    held_addr = mem_req.addr;
                    refill_count++;
                    check_value("mem_req.addr", mem_req.addr, exp_addr);
                end
                check_value("mem_req.addr held", mem_req.addr, held_addr);
                if (wait_cnt == mem_delay)
                begin
                    mem_rsp.ready = 1'b1;
                    mem_rsp.data = ref_mem_word(mem_req.addr);
                    busy = 1'b0;
                end
                else
                    wait_cnt++;
            end
        end
    end

    // compare process samples mid-cycle
    always @(negedge clk)
    begin
        if (!rst && cpu_req_ready)
        begin
            if (responses == issued)
                stop_with_error("cpu_req_ready pulsed with no request pending");
            check_value("cpu_req_data", cpu_req_data, exp_data);
            check_value("refill count", 32'(refill_count - refills_at_issue), 32'(exp_miss));
            if (!exp_miss)
                check_value("cpu_req_ready latency", 32'(cycle - issue_cycle), 32'd2);
            responses <= responses + 1;
        end
    end

    initial
    begin
        int          i;
        logic [31:0] r;
        rst = 1'b1;
        flush = 1'b0;
        cpu_req_addr = '0;
        cpu_req_valid = 1'b0;
        repeat (4) @(posedge clk);
        #SKEW;
        rst = 1'b0;
        check_value("cpu_req_ready", 32'(cpu_req_ready), 32'h0);
        check_value("mem_req.valid", 32'(mem_req.valid), 32'h0);

        // cold misses including one unaligned and one with high bits set
        for (i = 0; i < 4; i++)
            fetch(32'h0000_1000 + i * 4);
        fetch(32'h0000_1012);
        fetch(32'habc0_1054);

        // same addresses again should all hit
        for (i = 0; i < 4; i++)
            fetch(32'h0000_1000 + i * 4);
        fetch(32'h0000_1012);
        fetch(32'habc0_1054);

        // index 0 with two tags
        for (i = 0; i < 4; i++)
        begin
            fetch(32'h0000_2040);
            fetch(32'h0000_6040);
        end

        // slow memory
        fetch_delayed(32'h0000_3008, 7);
        fetch_delayed(32'h0000_300c, 5);
        fetch_delayed(32'h0000_3008, 0);

        flush_cache();
        fetch(32'h0000_1004);
        fetch(32'h0000_1008);
        fetch(32'habc0_1054);
        fetch(32'h0000_1004);

        // random mix over 64 words
        for (i = 0; i < 300; i++)
        begin
            take_bits(6, r);
            fetch(32'h0000_4000 + (r << 2));
        end

        repeat (4) @(posedge clk);
        if (responses == issued)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            $display("%0d of %0d fetches got no response", issued - responses, issued);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule
